// File: Makefile
TOP = mipsBusCpuTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -o simv
	./obj_dir/simv | tee sim.log
	grep -q "^TEST PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: hw/executeUnit.sv
`timescale 1ns/1ns
`default_nettype none

module executeUnit (
    input  logic clk,
    input  logic reset,
    input  mipsPkg::stageT stage,
    input  mipsPkg::instrWordT instr,
    input  logic [mipsPkg::DataWidth-1:0] pc,
    input  logic [mipsPkg::DataWidth-1:0] readDataA,
    input  logic [mipsPkg::DataWidth-1:0] readDataB,
    input  logic [mipsPkg::DataWidth-1:0] loadData,
    output logic [mipsPkg::RegAddrWidth-1:0] readAddrA,
    output logic [mipsPkg::RegAddrWidth-1:0] readAddrB,
    output logic writeEnable,
    output logic [mipsPkg::RegAddrWidth-1:0] writeAddr,
    output logic [mipsPkg::DataWidth-1:0] writeData,
    output logic jumpTaken,
    output logic [mipsPkg::DataWidth-1:0] jumpTarget,
    output logic [mipsPkg::DataWidth-1:0] memAddress,
    output logic [mipsPkg::DataWidth-1:0] storeData,
    output logic needsMemory,
    output logic isStore,
    output logic skipsWriteBack,
    output logic haltJump
);

    logic [mipsPkg::DataWidth-1:0] opA;
    logic [mipsPkg::DataWidth-1:0] opB;
    logic [mipsPkg::DataWidth-1:0] result;
    logic [mipsPkg::DataWidth-1:0] immSigned;
    logic [mipsPkg::DataWidth-1:0] immZero;
    logic [mipsPkg::DataWidth-1:0] seqPc;
    logic [mipsPkg::DataWidth-1:0] aluValue;
    logic [mipsPkg::DataWidth-1:0] targetValue;
    logic isSpecial;
    logic isJr;
    logic isJump;
    logic isLoad;
    logic isAluI;
    logic isBranch;
    logic branchCond;
    logic writesReg;

    assign readAddrA = instr.rFields.rs;
    assign readAddrB = instr.rFields.rt;

    assign isSpecial = (instr.rFields.opcode == mipsPkg::OpSpecial);
    assign isJr = isSpecial && (instr.rFields.funct == mipsPkg::FnJr);
    assign isJump = (instr.jFields.opcode == mipsPkg::OpJ);
    assign isLoad = (instr.iFields.opcode == mipsPkg::OpLw);
    assign isStore = (instr.iFields.opcode == mipsPkg::OpSw);

    assign immSigned = {{16{instr.iFields.imm[15]}}, instr.iFields.imm};
    assign immZero = {16'b0, instr.iFields.imm};
    assign seqPc = pc + mipsPkg::ByteCount;

    // I-type classes and branch condition
    always_comb begin
        isAluI = 1'b0;
        isBranch = 1'b0;
        branchCond = 1'b0;
        case (instr.iFields.opcode)
            mipsPkg::OpAddiu, mipsPkg::OpSlti, mipsPkg::OpSltiu, mipsPkg::OpAndi,
            mipsPkg::OpOri, mipsPkg::OpXori, mipsPkg::OpLui: begin
                isAluI = 1'b1;
            end
            mipsPkg::OpBeq: begin
                isBranch = 1'b1;
                branchCond = (opA == opB);
            end
            mipsPkg::OpBne: begin
                isBranch = 1'b1;
                branchCond = (opA != opB);
            end
            mipsPkg::OpBlez: begin
                isBranch = 1'b1;
                branchCond = ($signed(opA) <= 0);
            end
            mipsPkg::OpBgtz: begin
                isBranch = 1'b1;
                branchCond = ($signed(opA) > 0);
            end
            default: begin
                isAluI = 1'b0;
            end
        endcase
    end

    always_comb begin
        aluValue = '0;
        if (isSpecial) begin
            case (instr.rFields.funct)
                mipsPkg::FnAddu: aluValue = opA + opB;
                mipsPkg::FnSubu: aluValue = opA - opB;
                mipsPkg::FnAnd:  aluValue = opA & opB;
                mipsPkg::FnOr:   aluValue = opA | opB;
                mipsPkg::FnXor:  aluValue = opA ^ opB;
                mipsPkg::FnSlt:  aluValue[0] = ($signed(opA) < $signed(opB));
                mipsPkg::FnSltu: aluValue[0] = (opA < opB);
                mipsPkg::FnSll:  aluValue = opB << instr.rFields.shamt;
                mipsPkg::FnSrl:  aluValue = opB >> instr.rFields.shamt;
                mipsPkg::FnSra:  aluValue = $signed(opB) >>> instr.rFields.shamt;
                default:         aluValue = '0;
            endcase
        end else begin
            case (instr.iFields.opcode)
                mipsPkg::OpAddiu: aluValue = opA + immSigned;
                mipsPkg::OpSlti:  aluValue[0] = ($signed(opA) < $signed(immSigned));
                // Immediate is sign-extended, then compared unsigned
                mipsPkg::OpSltiu: aluValue[0] = (opA < immSigned);
                mipsPkg::OpAndi:  aluValue = opA & immZero;
                mipsPkg::OpOri:   aluValue = opA | immZero;
                mipsPkg::OpXori:  aluValue = opA ^ immZero;
                mipsPkg::OpLui:   aluValue = {instr.iFields.imm, 16'b0};
                default:          aluValue = '0;
            endcase
        end
    end

    // JR, J region jump, or PC-relative branch
    always_comb begin
        if (isJr) begin
            targetValue = opA;
        end else if (isJump) begin
            targetValue = {seqPc[31:28], instr.jFields.target, 2'b00};
        end else begin
            targetValue = seqPc + (immSigned << 2);
        end
    end

    assign writesReg = (isSpecial && !isJr) || isAluI || isLoad;
    assign needsMemory = isLoad || isStore;
    assign skipsWriteBack = !writesReg;
    assign haltJump = isJr && (opA == mipsPkg::HaltAddress);
    assign storeData = opB;

    assign writeEnable = (stage == mipsPkg::WriteBack);
    assign writeAddr = isSpecial ? instr.rFields.rd : instr.iFields.rt;
    assign writeData = isLoad ? loadData : result;

    always_ff @(posedge clk) begin
        if (reset) begin
            jumpTaken <= 1'b0;
        end else if (stage == mipsPkg::Execute) begin
            jumpTaken <= (isBranch && branchCond) || isJump || isJr;
        end
    end

    always_ff @(posedge clk) begin
        // Operands latched during register read
        if (stage == mipsPkg::Decode) begin
            opA <= readDataA;
            opB <= readDataB;
        end
        if (stage == mipsPkg::Execute) begin
            result <= aluValue;
            memAddress <= opA + immSigned;
            jumpTarget <= targetValue;
        end
    end

endmodule

`default_nettype wire

// File: hw/fetchUnit.sv
`timescale 1ns/1ns
`default_nettype none

module fetchUnit (
    input  logic clk,
    input  logic reset,
    input  mipsPkg::stageT stage,
    input  logic waitrequest,
    input  logic [mipsPkg::DataWidth-1:0] readdata,
    input  logic jumpTaken,
    input  logic [mipsPkg::DataWidth-1:0] jumpTarget,
    output logic [mipsPkg::DataWidth-1:0] fetchAddress,
    output logic fetchRead,
    output logic fetchDone,
    output mipsPkg::instrWordT instr,
    output logic [mipsPkg::DataWidth-1:0] pc
);

    logic pendingValid;
    logic [mipsPkg::DataWidth-1:0] pendingTarget;
    logic [mipsPkg::DataWidth-1:0] nextAddress;
    logic [mipsPkg::DataWidth-1:0] swappedWord;

    // A pending jump overrides the sequential address once
    assign nextAddress = pendingValid ? pendingTarget : pc + mipsPkg::ByteCount;

    assign fetchRead = (stage == mipsPkg::Fetch);
    assign fetchAddress = fetchRead ? nextAddress : '0;
    assign fetchDone = fetchRead && !waitrequest;

    // Bus words arrive little-endian
    always_comb begin
        for (int i = 0; i < mipsPkg::ByteCount; i++) begin
            swappedWord[8*i +: 8] = readdata[8*(mipsPkg::ByteCount-1-i) +: 8];
        end
    end

    // Reset behaves like a jump to the reset vector
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
            pendingValid <= 1'b1;
            pendingTarget <= mipsPkg::ResetVector;
        end else if (fetchDone) begin
            pc <= nextAddress;
            // Decision of the previous instruction takes effect after this delay slot
            pendingValid <= jumpTaken;
            pendingTarget <= jumpTarget;
        end
    end

    always_ff @(posedge clk) begin
        if (fetchDone) begin
            instr <= swappedWord;
        end
    end

endmodule

`default_nettype wire

// File: hw/memoryAccess.sv
`timescale 1ns/1ns
`default_nettype none

module memoryAccess (
    input  logic clk,
    input  logic reset,
    input  mipsPkg::stageT stage,
    input  logic waitrequest,
    input  logic [mipsPkg::DataWidth-1:0] readdata,
    input  logic [mipsPkg::DataWidth-1:0] memAddress,
    input  logic [mipsPkg::DataWidth-1:0] storeData,
    input  logic isStore,
    output logic [mipsPkg::DataWidth-1:0] memAddrOut,
    output logic memRead,
    output logic memWrite,
    output logic [mipsPkg::DataWidth-1:0] writedata,
    output logic [3:0] byteenable,
    output logic [mipsPkg::DataWidth-1:0] loadData,
    output logic memDone
);

    logic inMemory;
    logic [mipsPkg::DataWidth-1:0] swappedLoad;

    assign inMemory = (stage == mipsPkg::Memory);

    // Strobe stays up until the slave drops waitrequest
    assign memRead = inMemory && !isStore;
    assign memWrite = inMemory && isStore;
    assign memAddrOut = inMemory ? memAddress : '0;
    assign memDone = inMemory && !waitrequest;

    // Word accesses only
    assign byteenable = '1;

    // Register values go out and come back byte-reversed
    always_comb begin
        for (int i = 0; i < mipsPkg::ByteCount; i++) begin
            writedata[8*i +: 8] = storeData[8*(mipsPkg::ByteCount-1-i) +: 8];
            swappedLoad[8*i +: 8] = readdata[8*(mipsPkg::ByteCount-1-i) +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            loadData <= '0;
        end else if (memDone && memRead) begin
            loadData <= swappedLoad;
        end
    end

endmodule

`default_nettype wire

// File: hw/mipsBusCpu.sv
`timescale 1ns/1ns
`default_nettype none

module mipsBusCpu (
    input  logic clk,
    input  logic reset,
    output logic active,
    output logic [mipsPkg::DataWidth-1:0] register_v0,
    output logic [mipsPkg::DataWidth-1:0] address,
    output logic read,
    output logic write,
    input  logic waitrequest,
    output logic [mipsPkg::DataWidth-1:0] writedata,
    output logic [3:0] byteenable,
    input  logic [mipsPkg::DataWidth-1:0] readdata
);

    mipsPkg::stageT stage;
    mipsPkg::instrWordT instr;

    logic fetchDone;
    logic memDone;
    logic needsMemory;
    logic isStore;
    logic skipsWriteBack;
    logic haltJump;
    logic fetchRead;
    logic memRead;
    logic memWrite;
    logic jumpTaken;
    logic writeEnable;
    logic [mipsPkg::RegAddrWidth-1:0] readAddrA;
    logic [mipsPkg::RegAddrWidth-1:0] readAddrB;
    logic [mipsPkg::RegAddrWidth-1:0] writeAddr;
    logic [mipsPkg::DataWidth-1:0] fetchAddress;
    logic [mipsPkg::DataWidth-1:0] memAddrOut;
    logic [mipsPkg::DataWidth-1:0] pc;
    logic [mipsPkg::DataWidth-1:0] jumpTarget;
    logic [mipsPkg::DataWidth-1:0] readDataA;
    logic [mipsPkg::DataWidth-1:0] readDataB;
    logic [mipsPkg::DataWidth-1:0] writeData;
    logic [mipsPkg::DataWidth-1:0] memAddress;
    logic [mipsPkg::DataWidth-1:0] storeData;
    logic [mipsPkg::DataWidth-1:0] loadData;

    // Fetch and memory stages drive zeros outside their own stage
    assign address = fetchAddress | memAddrOut;
    assign read = fetchRead | memRead;
    assign write = memWrite;

    stageSequencer sequencer (
        .clk(clk),
        .reset(reset),
        .fetchDone(fetchDone),
        .memDone(memDone),
        .needsMemory(needsMemory),
        .skipsWriteBack(skipsWriteBack),
        .haltJump(haltJump),
        .stage(stage),
        .active(active)
    );

    fetchUnit fetch (
        .clk(clk),
        .reset(reset),
        .stage(stage),
        .waitrequest(waitrequest),
        .readdata(readdata),
        .jumpTaken(jumpTaken),
        .jumpTarget(jumpTarget),
        .fetchAddress(fetchAddress),
        .fetchRead(fetchRead),
        .fetchDone(fetchDone),
        .instr(instr),
        .pc(pc)
    );

    registerFile regs (
        .clk(clk),
        .reset(reset),
        .readAddrA(readAddrA),
        .readAddrB(readAddrB),
        .writeEnable(writeEnable),
        .writeAddr(writeAddr),
        .writeData(writeData),
        .readDataA(readDataA),
        .readDataB(readDataB),
        .v0(register_v0)
    );

    executeUnit execute (
        .clk(clk),
        .reset(reset),
        .stage(stage),
        .instr(instr),
        .pc(pc),
        .readDataA(readDataA),
        .readDataB(readDataB),
        .loadData(loadData),
        .readAddrA(readAddrA),
        .readAddrB(readAddrB),
        .writeEnable(writeEnable),
        .writeAddr(writeAddr),
        .writeData(writeData),
        .jumpTaken(jumpTaken),
        .jumpTarget(jumpTarget),
        .memAddress(memAddress),
        .storeData(storeData),
        .needsMemory(needsMemory),
        .isStore(isStore),
        .skipsWriteBack(skipsWriteBack),
        .haltJump(haltJump)
    );

    memoryAccess memory (
        .clk(clk),
        .reset(reset),
        .stage(stage),
        .waitrequest(waitrequest),
        .readdata(readdata),
        .memAddress(memAddress),
        .storeData(storeData),
        .isStore(isStore),
        .memAddrOut(memAddrOut),
        .memRead(memRead),
        .memWrite(memWrite),
        .writedata(writedata),
        .byteenable(byteenable),
        .loadData(loadData),
        .memDone(memDone)
    );

endmodule

`default_nettype wire

// File: hw/mipsPkg.sv
`default_nettype none

package mipsPkg;

    localparam int DataWidth = 32;
    localparam int RegAddrWidth = 5;

    // First fetch after reset
    localparam logic [DataWidth-1:0] ResetVector = 32'hBFC0_0000;
    // JR to this address stops the core
    localparam logic [DataWidth-1:0] HaltAddress = '0;

    // Bytes per word, also the sequential PC step
    localparam logic [2:0] ByteCount = 3'd4;

    typedef enum logic [2:0] {
        Fetch,
        Decode,
        Execute,
        Memory,
        WriteBack,
        Halt
    } stageT;

    // Major opcodes handled by the core
    typedef enum logic [5:0] {
        OpSpecial = 6'd0,
        OpJ       = 6'd2,
        OpBeq     = 6'd4,
        OpBne     = 6'd5,
        OpBlez    = 6'd6,
        OpBgtz    = 6'd7,
        OpAddiu   = 6'd9,
        OpSlti    = 6'd10,
        OpSltiu   = 6'd11,
        OpAndi    = 6'd12,
        OpOri     = 6'd13,
        OpXori    = 6'd14,
        OpLui     = 6'd15,
        OpLw      = 6'd35,
        OpSw      = 6'd43
    } opcodeT;

    // Function codes under OpSpecial
    typedef enum logic [5:0] {
        FnSll  = 6'd0,
        FnSrl  = 6'd2,
        FnSra  = 6'd3,
        FnJr   = 6'd8,
        FnAddu = 6'd33,
        FnSubu = 6'd35,
        FnAnd  = 6'd36,
        FnOr   = 6'd37,
        FnXor  = 6'd38,
        FnSlt  = 6'd42,
        FnSltu = 6'd43
    } functT;

    typedef struct packed {
        opcodeT opcode;
        logic [RegAddrWidth-1:0] rs;
        logic [RegAddrWidth-1:0] rt;
        logic [RegAddrWidth-1:0] rd;
        logic [4:0] shamt;
        functT funct;
    } rFieldsT;

    typedef struct packed {
        opcodeT opcode;
        logic [RegAddrWidth-1:0] rs;
        logic [RegAddrWidth-1:0] rt;
        logic [15:0] imm;
    } iFieldsT;

    typedef struct packed {
        opcodeT opcode;
        logic [25:0] target;
    } jFieldsT;

    // Same 32 bits seen as R, I or J format
    typedef union packed {
        rFieldsT rFields;
        iFieldsT iFields;
        jFieldsT jFields;
    } instrWordT;

endpackage

`default_nettype wire

// File: hw/registerFile.sv
`timescale 1ns/1ns
`default_nettype none

module registerFile (
    input  logic clk,
    input  logic reset,
    input  logic [mipsPkg::RegAddrWidth-1:0] readAddrA,
    input  logic [mipsPkg::RegAddrWidth-1:0] readAddrB,
    input  logic writeEnable,
    input  logic [mipsPkg::RegAddrWidth-1:0] writeAddr,
    input  logic [mipsPkg::DataWidth-1:0] writeData,
    output logic [mipsPkg::DataWidth-1:0] readDataA,
    output logic [mipsPkg::DataWidth-1:0] readDataB,
    output logic [mipsPkg::DataWidth-1:0] v0
);

    logic [mipsPkg::DataWidth-1:0] regs [2**mipsPkg::RegAddrWidth];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**mipsPkg::RegAddrWidth; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && (writeAddr != '0)) begin
            // Register 0 never takes a write
            regs[writeAddr] <= writeData;
        end
    end

    assign readDataA = regs[readAddrA];
    assign readDataB = regs[readAddrB];

    // v0 is register 2
    assign v0 = regs[2];

endmodule

`default_nettype wire

// File: hw/stageSequencer.sv
`timescale 1ns/1ns
`default_nettype none

module stageSequencer (
    input  logic clk,
    input  logic reset,
    input  logic fetchDone,
    input  logic memDone,
    input  logic needsMemory,
    input  logic skipsWriteBack,
    input  logic haltJump,
    output mipsPkg::stageT stage,
    output logic active
);

    mipsPkg::stageT nextStage;

    always_comb begin
        nextStage = stage;
        case (stage)
            mipsPkg::Fetch: begin
                // Held until the bus accepts the read
                if (fetchDone) begin
                    nextStage = mipsPkg::Decode;
                end
            end
            mipsPkg::Decode: begin
                nextStage = mipsPkg::Execute;
            end
            mipsPkg::Execute: begin
                if (haltJump) begin
                    nextStage = mipsPkg::Halt;
                end else if (needsMemory) begin
                    nextStage = mipsPkg::Memory;
                end else if (skipsWriteBack) begin
                    nextStage = mipsPkg::Fetch;
                end else begin
                    nextStage = mipsPkg::WriteBack;
                end
            end
            mipsPkg::Memory: begin
                // Stores finish here, loads still write a register
                if (memDone) begin
                    nextStage = skipsWriteBack ? mipsPkg::Fetch : mipsPkg::WriteBack;
                end
            end
            mipsPkg::WriteBack: begin
                nextStage = mipsPkg::Fetch;
            end
            default: begin
                nextStage = mipsPkg::Halt;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage <= mipsPkg::Fetch;
            active <= 1'b1;
        end else begin
            stage <= nextStage;
            active <= (nextStage != mipsPkg::Halt);
        end
    end

endmodule

`default_nettype wire

// File: src.f
hw/mipsPkg.sv
hw/stageSequencer.sv
hw/fetchUnit.sv
hw/registerFile.sv
hw/executeUnit.sv
hw/memoryAccess.sv
hw/mipsBusCpu.sv
tb/avalonMemModel.sv
tb/mipsBusCpuTb.sv

// File: tb/avalonMemModel.sv
`timescale 1ns/1ns
`default_nettype none

module avalonMemModel (
    input  logic clk,
    input  logic [31:0] address,
    input  logic read,
    input  logic write,
    input  logic [31:0] writedata,
    output logic [31:0] readdata,
    output logic waitrequest
);

    localparam int Words = 256;

    // Words as the program sees them, big-endian byte order
    logic [31:0] words [Words];
    integer seed;

    function automatic logic [31:0] swapBytes(input logic [31:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    // Bus carries the lowest address byte in bits 7:0
    assign readdata = read ? swapBytes(words[address[9:2]]) : '0;

    task automatic fillMemory();
        for (int i = 0; i < Words; i++) begin
            words[i] = 32'hFC00_0000 | 32'(i << 2);
        end
    endtask

    task automatic loadWord(input int index, input logic [31:0] value);
        words[index] = value;
    endtask

    initial begin
        seed = 32'he1a5afb3;
        waitrequest = 1'b0;
        fillMemory();
    end

    // Stall roughly one cycle in four
    always @(negedge clk) begin
        waitrequest = (($random(seed) & 3) == 0);
    end

    always @(posedge clk) begin
        if (write && !waitrequest) begin
            words[address[9:2]] = swapBytes(writedata);
        end
    end

endmodule

`default_nettype wire

// File: tb/mipsBusCpuTb.sv
`timescale 1ns/1ns
`default_nettype none

module mipsBusCpuTb;

    localparam int HaltTimeout = 4000;
    localparam logic [31:0] ProgramBase = 32'hBFC0_0000;

    logic clk;
    logic reset;
    logic active;
    logic [31:0] registerV0;
    logic [31:0] address;
    logic read;
    logic write;
    logic waitrequest;
    logic [31:0] writedata;
    logic [3:0] byteenable;
    logic [31:0] readdata;

    int errors = 0;
    int testsRun = 0;
    int testsFailed = 0;
    int stallChecks = 0;
    int storesSeen = 0;
    logic [31:0] expectedStore;
    logic heldWait;
    logic heldRead;
    logic heldWrite;
    logic [31:0] heldAddr;
    logic [31:0] progWords[$];

    mipsBusCpu UUT (
        .clk(clk),
        .reset(reset),
        .active(active),
        .register_v0(registerV0),
        .address(address),
        .read(read),
        .write(write),
        .waitrequest(waitrequest),
        .writedata(writedata),
        .byteenable(byteenable),
        .readdata(readdata)
    );

    avalonMemModel memModel (
        .clk(clk),
        .address(address),
        .read(read),
        .write(write),
        .writedata(writedata),
        .readdata(readdata),
        .waitrequest(waitrequest)
    );

    initial begin
        clk = 1'b0;
    end

    always #4 clk = ~clk;

    function automatic logic [31:0] rType(input int rs, input int rt, input int rd,
                                          input int shamt, input int funct);
        return {6'd0, rs[4:0], rt[4:0], rd[4:0], shamt[4:0], funct[5:0]};
    endfunction

    function automatic logic [31:0] iType(input int op, input int rs, input int rt,
                                          input logic [15:0] imm);
        return {op[5:0], rs[4:0], rt[4:0], imm};
    endfunction

    function automatic logic [31:0] jType(input int op, input logic [31:0] target);
        return {op[5:0], target[27:2]};
    endfunction

    function automatic logic [31:0] swapBytes(input logic [31:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        assert (got === expected) else begin
            $display("MISMATCH %s got 0x%h expected 0x%h", name, got, expected);
            errors++;
        end
    endtask

    task automatic checkTrue(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            $display("ERROR %s", what);
            errors++;
        end
    endtask

    task automatic reportTest(input string name, input int startErrors);
        testsRun++;
        if (errors == startErrors) begin
            $display("%s: passed", name);
        end else begin
            testsFailed++;
            $display("%s: failed with %0d errors", name, errors - startErrors);
        end
    endtask

    // Stalled bus cycles must hold strobes and address
    always @(posedge clk) begin
        if (heldWait && (heldRead || heldWrite)) begin
            stallChecks++;
            checkValue("address", address, heldAddr);
            checkValue("read", {31'b0, read}, {31'b0, heldRead});
            checkValue("write", {31'b0, write}, {31'b0, heldWrite});
        end
        if (write && !waitrequest && !reset) begin
            storesSeen++;
            checkValue("byteenable", {28'b0, byteenable}, 32'h0000_000F);
            checkValue("writedata", writedata, swapBytes(expectedStore));
        end
        heldWait = waitrequest && !reset;
        heldRead = read;
        heldWrite = write;
        heldAddr = address;
    end

    // Loads the program, resets, runs to the halting JR and checks v0
    task automatic runProgram(input string name, input logic [31:0] expectedV0);
        int cycles;
        @(negedge clk);
        reset = 1'b1;
        memModel.fillMemory();
        foreach (progWords[i]) begin
            memModel.loadWord(i, progWords[i]);
        end
        repeat (2) @(negedge clk);
        reset = 1'b0;
        checkTrue(active, "active is not high after reset");
        checkTrue(!write, "write is not low after reset");
        checkTrue(read, "no read in the first fetch cycle");
        checkValue("address", address, ProgramBase);
        cycles = 0;
        while (active === 1'b1 && cycles < HaltTimeout) begin
            @(negedge clk);
            cycles++;
        end
        checkTrue(active !== 1'b1,
                  $sformatf("%s did not halt within %0d cycles", name, HaltTimeout));
        if (active !== 1'b1) begin
            repeat (20) begin
                @(negedge clk);
                checkTrue(!active && !read && !write, "core left the halt state");
            end
            checkValue("register_v0", registerV0, expectedV0);
        end
    endtask

    task automatic aluTest();
        int startErrors;
        logic [31:0] r8, r9, r23, r12, r13, r14, r15, r16, r24, v;
        logic f10, f11, f18, f19, f20;
        startErrors = errors;
        progWords.delete();
        progWords.push_back(iType(15, 0, 8, 16'h8000));
        progWords.push_back(iType(13, 8, 8, 16'h1234));
        progWords.push_back(iType(9, 0, 9, 16'hFFFB));
        progWords.push_back(iType(9, 0, 23, 16'h0010));
        progWords.push_back(rType(8, 23, 10, 0, 42));
        progWords.push_back(rType(23, 8, 11, 0, 43));
        progWords.push_back(iType(14, 9, 12, 16'hFFFF));
        progWords.push_back(iType(12, 9, 13, 16'h8001));
        progWords.push_back(rType(0, 8, 14, 4, 3));
        progWords.push_back(rType(0, 8, 15, 4, 2));
        progWords.push_back(rType(0, 9, 16, 3, 0));
        progWords.push_back(iType(10, 9, 18, 16'hFFFC));
        progWords.push_back(iType(11, 9, 19, 16'hFFFC));
        progWords.push_back(iType(11, 8, 20, 16'h0020));
        progWords.push_back(rType(12, 13, 2, 0, 33));
        progWords.push_back(rType(2, 14, 2, 0, 38));
        progWords.push_back(rType(2, 15, 2, 0, 35));
        progWords.push_back(rType(2, 16, 2, 0, 37));
        progWords.push_back(rType(8, 16, 24, 0, 36));
        progWords.push_back(rType(2, 24, 2, 0, 38));
        // Shift the five compare flags into the low bits of v0
        for (int k = 0; k < 5; k++) begin
            progWords.push_back(rType(0, 2, 2, 1, 0));
            progWords.push_back(rType(2, (k < 2) ? 10 + k : 16 + k, 2, 0, 37));
        end
        progWords.push_back(rType(0, 0, 0, 0, 8));
        progWords.push_back(32'h0);
        r8 = 32'h8000_0000 | 32'h0000_1234;
        r9 = 32'hFFFF_FFFB;
        r23 = 32'h0000_0010;
        f10 = $signed(r8) < $signed(r23);
        f11 = r23 < r8;
        r12 = r9 ^ 32'h0000_FFFF;
        r13 = r9 & 32'h0000_8001;
        r14 = $signed(r8) >>> 4;
        r15 = r8 >> 4;
        r16 = r9 << 3;
        r24 = r8 & r16;
        f18 = $signed(r9) < $signed(32'hFFFF_FFFC);
        f19 = r9 < 32'hFFFF_FFFC;
        f20 = r8 < 32'h0000_0020;
        v = (((((r12 + r13) ^ r14) - r15) | r16) ^ r24);
        v = {v[30:0], 1'b0} | {31'b0, f10};
        v = {v[30:0], 1'b0} | {31'b0, f11};
        v = {v[30:0], 1'b0} | {31'b0, f18};
        v = {v[30:0], 1'b0} | {31'b0, f19};
        v = {v[30:0], 1'b0} | {31'b0, f20};
        runProgram("alu", v);
        reportTest("alu", startErrors);
    endtask

    task automatic storeLoadTest();
        int startErrors;
        startErrors = errors;
        expectedStore = 32'h1234_5678;
        storesSeen = 0;
        progWords.delete();
        progWords.push_back(iType(15, 0, 8, 16'h1234));
        progWords.push_back(iType(13, 8, 8, 16'h5678));
        progWords.push_back(iType(9, 0, 9, 16'h0100));
        progWords.push_back(iType(43, 9, 8, 16'h0020));
        progWords.push_back(iType(9, 0, 2, 16'h0007));
        progWords.push_back(iType(35, 9, 2, 16'h0020));
        progWords.push_back(rType(0, 0, 0, 0, 8));
        progWords.push_back(32'h0);
        runProgram("storeLoad", expectedStore);
        checkTrue(storesSeen == 1, "store did not reach the bus exactly once");
        checkValue("memory word 0x120", memModel.words[8'h48], expectedStore);
        reportTest("storeLoad", startErrors);
    endtask

    task automatic branchTest();
        int startErrors;
        startErrors = errors;
        progWords.delete();
        progWords.push_back(iType(9, 0, 8, 16'h0005));
        progWords.push_back(iType(9, 0, 9, 16'hFFFD));
        progWords.push_back(iType(4, 8, 9, 16'h0002));
        progWords.push_back(iType(9, 2, 2, 16'h0001));
        progWords.push_back(iType(5, 8, 9, 16'h0002));
        progWords.push_back(iType(9, 2, 2, 16'h0002));
        progWords.push_back(iType(9, 2, 2, 16'h0100));
        progWords.push_back(iType(7, 8, 0, 16'h0002));
        progWords.push_back(iType(9, 2, 2, 16'h0004));
        progWords.push_back(iType(9, 2, 2, 16'h0200));
        progWords.push_back(iType(6, 8, 0, 16'h0005));
        progWords.push_back(iType(9, 2, 2, 16'h0008));
        progWords.push_back(iType(6, 9, 0, 16'h0002));
        progWords.push_back(iType(9, 2, 2, 16'h0010));
        progWords.push_back(iType(9, 2, 2, 16'h0400));
        progWords.push_back(iType(7, 9, 0, 16'h0005));
        progWords.push_back(iType(9, 2, 2, 16'h0020));
        progWords.push_back(jType(2, ProgramBase + 32'd80));
        progWords.push_back(iType(9, 2, 2, 16'h0040));
        progWords.push_back(iType(9, 2, 2, 16'h0800));
        progWords.push_back(iType(4, 8, 8, 16'h0002));
        progWords.push_back(iType(9, 2, 2, 16'h0080));
        progWords.push_back(iType(9, 2, 2, 16'h1000));
        progWords.push_back(rType(0, 0, 0, 0, 8));
        progWords.push_back(32'h0);
        // Every delay slot runs, every skipped word stays out of v0
        runProgram("branch", 32'h1 + 32'h2 + 32'h4 + 32'h8 + 32'h10 + 32'h20 + 32'h40 + 32'h80);
        reportTest("branch", startErrors);
    endtask

    initial begin
        int startErrors;
        reset = 1'b1;
        expectedStore = '0;
        heldWait = 1'b0;
        heldRead = 1'b0;
        heldWrite = 1'b0;
        heldAddr = '0;
        aluTest();
        storeLoadTest();
        branchTest();
        startErrors = errors;
        checkTrue(stallChecks > 0, "no stalled bus cycle was observed");
        reportTest("backpressure", startErrors);
        $display("tests %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
        if (errors == 0 && testsFailed == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
